/* files.f */
+incdir+.
link_calib_pkg.sv
link_chan_pkg.sv
calib_sequencer.sv
chan_output.sv
chan_input.sv
link_master_top.sv
tb_clkgen.sv
tb_link_master.sv

/* Makefile */
# Verilator build and run for the link master testbench

VERILATOR ?= verilator
TOP       ?= tb_link_master
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_link_master.sv */
// testbench for the link master: loopback wiring, calibration checks and credit-flow traffic
`timescale 1ns/1ns
`include "link_cfg.svh"

module tb_link_master;

  localparam int n_ch           = `LINK_CHANNELS;
  localparam int fifo_depth     = 1 << `LG_FIFO_DEPTH;
  localparam int traffic_cycles = 400;

  logic                      io_master_clk;
  logic                      rst_n;
  logic                      reset_req;
  logic                      fault;
  logic [n_ch-1:0]           fault_mask;
  // dut ports
  logic                      core_calib_done;
  logic [n_ch-1:0]           core_active_channels;
  logic [n_ch-1:0]           core_valid_in;
  link_chan_pkg::chan_word_t core_data_in [n_ch];
  logic [n_ch-1:0]           core_ready;
  logic [n_ch-1:0]           core_valid_out;
  link_chan_pkg::chan_word_t core_data_out [n_ch];
  logic [n_ch-1:0]           core_yumi;
  logic [n_ch-1:0]           io_valid;
  link_chan_pkg::chan_word_t io_data [n_ch];
  logic [n_ch-1:0]           io_token;
  logic [n_ch-1:0]           im_valid;
  link_chan_pkg::chan_word_t im_data [n_ch];
  logic [n_ch-1:0]           token_clk;
  logic                      slave_reset;
  // reference model, expected words per channel with the oldest at the front
  link_chan_pkg::chan_word_t model_q [n_ch][$];
  integer                    seed;

  tb_clkgen clkgen (
    .reset_req_i    (reset_req),
    .io_master_clk_o(io_master_clk),
    .rst_n_o        (rst_n)
  );

  link_master_top UUT (
    .io_master_clk_i         (io_master_clk),
    .rst_n_i                 (rst_n),
    .core_calib_done_r_o     (core_calib_done),
    .core_active_channels_o  (core_active_channels),
    .core_valid_i            (core_valid_in),
    .core_data_i             (core_data_in),
    .core_ready_o            (core_ready),
    .core_valid_o            (core_valid_out),
    .core_data_o             (core_data_out),
    .core_yumi_i             (core_yumi),
    .io_valid_tline_i        (io_valid),
    .io_data_tline_i         (io_data),
    .io_token_clk_tline_o    (io_token),
    .im_valid_tline_o        (im_valid),
    .im_data_tline_o         (im_data),
    .token_clk_tline_i       (token_clk),
    .im_slave_reset_tline_r_o(slave_reset)
  );

  // ----------------------------------------------------------------------
  // loopback, master output lines fed straight back to its inputs
  // ----------------------------------------------------------------------
  assign io_valid  = im_valid;
  assign token_clk = io_token;

  always_comb begin
    for (int c = 0; c < n_ch; c++)
      io_data[c] = im_data[c];
    // injected fault flips bit 0 of channel 1
    if (fault)
      io_data[1][0] = ~im_data[1][0];
  end

  // ----------------------------------------------------------------------
  // helpers and compare tasks
  // ----------------------------------------------------------------------
  // sample and drive point, 2 ns after the rising edge
  task automatic step();
    @(posedge io_master_clk);
    #2;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string what, input link_chan_pkg::chan_word_t got,
                            input link_chan_pkg::chan_word_t exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h",
                          $time, what, got, exp));
  endtask

  task automatic check_mask(input string what, input logic [`LINK_CHANNELS-1:0] got,
                            input logic [`LINK_CHANNELS-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: %s, got %b, expected %b",
                          $time, what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: %s, got %b, expected %b",
                          $time, what, got, exp));
  endtask

  function automatic bit models_empty();
    for (int c = 0; c < n_ch; c++)
      if (model_q[c].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  // every control output low, during reset and just after it
  task automatic check_idle_outputs();
    check_bit("calibration done", core_calib_done, 1'b0);
    check_mask("active channels", core_active_channels, '0);
    check_mask("core ready", core_ready, '0);
    check_mask("core valid", core_valid_out, '0);
    check_mask("line valid", im_valid, '0);
    check_mask("token line", io_token, '0);
    check_bit("slave reset line", slave_reset, 1'b0);
  endtask

  // returns on the first sample after the first edge following release
  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n == 10) begin
        abort_run("timeout while waiting for reset release");
      end else begin
        step();
        n++;
      end
    end
  endtask

  // wait phase, then the registered slave reset for the prepare length
  task automatic check_prepare_window();
    for (int k = 1; k <= `WAIT_CYCLES; k++) begin
      check_bit("slave reset during wait", slave_reset, 1'b0);
      step();
    end
    for (int k = 0; k < `PREPARE_CYCLES; k++) begin
      check_bit("slave reset during prepare", slave_reset, 1'b1);
      check_bit("calibration done during prepare", core_calib_done, 1'b0);
      step();
    end
    check_bit("slave reset after prepare", slave_reset, 1'b0);
  endtask

  // every line carries the current test's word, one test after another
  task automatic check_calib_words();
    for (int t = 0; t < `NUM_TESTS; t++) begin
      for (int k = 0; k < `TEST_CYCLES; k++) begin
        for (int c = 0; c < n_ch; c++) begin
          check_bit("line valid during calibration", im_valid[c], 1'b1);
          check_word($sformatf("channel %0d calibration word, test %0d", c, t),
                     im_data[c], link_calib_pkg::calib_word[t]);
        end
        step();
      end
    end
  endtask

  task automatic wait_calib_done(input int limit);
    int n;
    n = 0;
    while (core_calib_done !== 1'b1) begin
      if (n == limit) begin
        abort_run("calibration done did not rise within the expected cycle count");
      end else begin
        step();
        n++;
      end
    end
  endtask

  // active vector is latched a couple of cycles after done
  task automatic wait_active();
    int n;
    n = 0;
    while (core_active_channels == '0) begin
      if (n == 8) begin
        abort_run("timeout while waiting for the active channel vector");
      end else begin
        step();
        n++;
      end
    end
  endtask

  task automatic wait_ready(input logic [`LINK_CHANNELS-1:0] want, input int limit);
    int n;
    n = 0;
    while ((core_ready & want) !== want) begin
      if (n == limit) begin
        abort_run("timeout while waiting for core ready to return");
      end else begin
        step();
        n++;
      end
    end
  endtask

  // fifo head must match the oldest word the model holds
  task automatic pop_compare(input int c);
    link_chan_pkg::chan_word_t exp;
    if (model_q[c].size() == 0) begin
      abort_run($sformatf("channel %0d handed the core a word that was never sent", c));
    end else begin
      exp = model_q[c].pop_front();
      check_word($sformatf("channel %0d received word", c), core_data_out[c], exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // traffic phases
  // ----------------------------------------------------------------------
  // offer a word every cycle without popping, credits run out at fifo depth
  task automatic fill_without_pops();
    link_chan_pkg::chan_word_t w;
    core_yumi = '0;
    for (int k = 0; k < fifo_depth + 20; k++) begin
      for (int c = 0; c < n_ch; c++) begin
        // accept shows on the line one cycle later, at the fifo head one more
        if (k < 2)
          check_bit("fifo empty before the first word lands", core_valid_out[c], 1'b0);
        if (k == 1)
          check_bit("line valid one cycle after accept", im_valid[c], 1'b1);
        if (k == 2)
          check_bit("fifo head two cycles after accept", core_valid_out[c], 1'b1);
        check_bit("core ready against remaining credits", core_ready[c], k < fifo_depth);
        w = link_chan_pkg::chan_word_t'($random(seed));
        core_valid_in[c] = 1'b1;
        core_data_in[c]  = w;
        if (core_ready[c])
          model_q[c].push_back(w);
      end
      step();
    end
    core_valid_in = '0;
  endtask

  task automatic drain_models(input int limit);
    int n;
    n = 0;
    core_valid_in = '0;
    while (!models_empty()) begin
      if (n == limit) begin
        abort_run("timeout while draining the receive fifos");
      end else begin
        for (int c = 0; c < n_ch; c++) begin
          core_yumi[c] = core_valid_out[c];
          if (core_valid_out[c])
            pop_compare(c);
        end
        step();
        n++;
      end
    end
    core_yumi = '0;
  endtask

  task automatic random_traffic();
    for (int k = 0; k < traffic_cycles; k++) begin
      for (int c = 0; c < n_ch; c++) begin
        // offer about three cycles in four, pop about one in two
        core_valid_in[c] = (($random(seed) & 3) != 0);
        core_data_in[c]  = link_chan_pkg::chan_word_t'($random(seed));
        if (core_valid_in[c] && core_ready[c])
          model_q[c].push_back(core_data_in[c]);
        core_yumi[c] = core_valid_out[c] && (($random(seed) & 1) != 0);
        if (core_yumi[c])
          pop_compare(c);
      end
      step();
    end
    core_valid_in = '0;
    core_yumi     = '0;
  endtask

  // failed channel keeps ready low even with data offered
  task automatic check_faulted_channel();
    core_valid_in[1] = 1'b1;
    for (int k = 0; k < 40; k++) begin
      check_bit("ready on the failed channel", core_ready[1], 1'b0);
      check_mask("active channels with fault", core_active_channels, fault_mask);
      step();
    end
    core_valid_in = '0;
    wait_ready(fault_mask, 8);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    seed          = 32'h2e46824c;
    reset_req     = 1'b0;
    fault         = 1'b0;
    fault_mask    = '1;
    fault_mask[1] = 1'b0;
    core_valid_in = '0;
    core_yumi     = '0;
    for (int c = 0; c < n_ch; c++)
      core_data_in[c] = '0;
    #1;
    check_idle_outputs();
    wait_reset_release();
    check_idle_outputs();
    check_prepare_window();

    // clean loopback, every channel passes
    check_calib_words();
    wait_calib_done(`NUM_TESTS * `TEST_CYCLES);
    wait_active();
    check_mask("active channels after clean calibration", core_active_channels, '1);
    wait_ready('1, 8);

    // back-pressure, then resume pops and drain in order
    fill_without_pops();
    drain_models(200);
    wait_ready('1, 16);

    random_traffic();
    drain_models(400);
    check_mask("core valid after drain", core_valid_out, '0);
    wait_ready('1, 16);

    // second run with channel 1 corrupted on the loopback
    fault     = 1'b1;
    reset_req = 1'b1;
    #1;
    check_idle_outputs();
    reset_req = 1'b0;
    wait_reset_release();
    wait_calib_done(`WAIT_CYCLES + `PREPARE_CYCLES + `NUM_TESTS * `TEST_CYCLES);
    wait_active();
    check_mask("active channels with fault", core_active_channels, fault_mask);
    check_faulted_channel();

    $display("test passed");
    $finish;
  end

endmodule

/* tb_clkgen.sv */
// testbench clock and reset source: 20 ns clock, two-cycle reset at start and on request
`timescale 1ns/1ns

module tb_clkgen (
  input  logic reset_req_i,
  output logic io_master_clk_o,
  output logic rst_n_o
);

  // free running clock, 20 ns period
  initial begin
    io_master_clk_o = 1'b0;
    forever #10 io_master_clk_o = ~io_master_clk_o;
  end

  // reset low across two rising edges, released on a falling edge
  // so release never lands on a sampling or driving point
  initial begin
    rst_n_o = 1'b0;
    forever begin
      repeat (2) @(posedge io_master_clk_o);
      @(negedge io_master_clk_o);
      rst_n_o = 1'b1;
      // next reset starts as soon as one is requested
      @(posedge reset_req_i);
      rst_n_o = 1'b0;
    end
  end

endmodule

/* link_master_top.sv */
// link master top: calibration sequencer plus one output and input per channel
`timescale 1ns/1ns
`include "link_cfg.svh"

module link_master_top (
  input  logic                       io_master_clk_i,
  input  logic                       rst_n_i,
  // core control
  output logic                       core_calib_done_r_o,
  output logic [`LINK_CHANNELS-1:0]  core_active_channels_o,
  // core to link
  input  logic [`LINK_CHANNELS-1:0]  core_valid_i,
  input  link_chan_pkg::chan_word_t  core_data_i [`LINK_CHANNELS],
  output logic [`LINK_CHANNELS-1:0]  core_ready_o,
  // link to core
  output logic [`LINK_CHANNELS-1:0]  core_valid_o,
  output link_chan_pkg::chan_word_t  core_data_o [`LINK_CHANNELS],
  input  logic [`LINK_CHANNELS-1:0]  core_yumi_i,
  // receive lines
  input  logic [`LINK_CHANNELS-1:0]  io_valid_tline_i,
  input  link_chan_pkg::chan_word_t  io_data_tline_i [`LINK_CHANNELS],
  output logic [`LINK_CHANNELS-1:0]  io_token_clk_tline_o,
  // transmit lines
  output logic [`LINK_CHANNELS-1:0]  im_valid_tline_o,
  output link_chan_pkg::chan_word_t  im_data_tline_o [`LINK_CHANNELS],
  input  logic [`LINK_CHANNELS-1:0]  token_clk_tline_i,
  // slave reset line
  output logic                       im_slave_reset_tline_r_o
);

  logic                      calib_active;
  link_calib_pkg::test_id_e  test_id;
  logic                      test_end;
  logic                      chan_clear;
  logic [`LINK_CHANNELS-1:0] chan_active;

  calib_sequencer seq (
    .io_master_clk_i  (io_master_clk_i),
    .rst_n_i          (rst_n_i),
    .chan_active_i    (chan_active),
    .calib_active_o   (calib_active),
    .test_id_o        (test_id),
    .test_end_o       (test_end),
    .chan_clear_o     (chan_clear),
    .calib_done_o     (core_calib_done_r_o),
    .slave_reset_r_o  (im_slave_reset_tline_r_o),
    .active_channels_o(core_active_channels_o)
  );

  // ----------------------------------------------------------------------
  // per-channel datapath
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `LINK_CHANNELS; i++) begin : ch
    // enabled from the latched active vector, so only after done
    chan_output sso (
      .io_master_clk_i(io_master_clk_i), .rst_n_i(rst_n_i),
      .chan_clear_i(chan_clear), .calib_active_i(calib_active), .test_id_i(test_id),
      .enable_i(core_active_channels_o[i]),
      .core_valid_i(core_valid_i[i]), .core_data_i(core_data_i[i]),
      .core_ready_o(core_ready_o[i]), .token_clk_i(token_clk_tline_i[i]),
      .im_valid_o(im_valid_tline_o[i]), .im_data_o(im_data_tline_o[i])
    );

    chan_input ssi (
      .io_master_clk_i(io_master_clk_i), .rst_n_i(rst_n_i),
      .chan_clear_i(chan_clear), .calib_active_i(calib_active), .test_id_i(test_id),
      .test_end_i(test_end),
      .io_valid_i(io_valid_tline_i[i]), .io_data_i(io_data_tline_i[i]),
      .core_valid_o(core_valid_o[i]), .core_data_o(core_data_o[i]),
      .core_yumi_i(core_yumi_i[i]), .token_o(io_token_clk_tline_o[i]),
      .chan_active_o(chan_active[i])
    );
  end

endmodule

/* chan_input.sv */
// per-channel input: calibration checker, receive fifo and token return
`timescale 1ns/1ns
`include "link_cfg.svh"

module chan_input (
  input  logic                       io_master_clk_i,
  input  logic                       rst_n_i,
  input  logic                       chan_clear_i,
  input  logic                       calib_active_i,
  input  link_calib_pkg::test_id_e   test_id_i,
  input  logic                       test_end_i,
  input  logic                       io_valid_i,
  input  link_chan_pkg::chan_word_t  io_data_i,
  output logic                       core_valid_o,
  output link_chan_pkg::chan_word_t  core_data_o,
  input  logic                       core_yumi_i,
  output logic                       token_o,
  output logic                       chan_active_o
);

  localparam link_calib_pkg::test_id_e last_test =
    link_calib_pkg::test_id_e'(`NUM_TESTS - 1);

  // check controls, delayed one cycle to line up with the output register
  logic                      chk_en_r;
  logic                      chk_end_r;
  link_calib_pkg::test_id_e  chk_id_r;
  logic                      test_ok_r;
  logic                      sample_ok;
  logic [`NUM_TESTS-1:0]     pass_r;
  logic [`NUM_TESTS-1:0]     pass_nxt;
  logic                      chan_active_r;
  logic                      cal_done_r;

  // fifo pointers carry an extra wrap bit
  link_chan_pkg::chan_word_t mem [2**`LG_FIFO_DEPTH];
  logic [`LG_FIFO_DEPTH:0]   wr_ptr_r;
  logic [`LG_FIFO_DEPTH:0]   rd_ptr_r;
  logic [`LG_TOKEN_DECIM-1:0] pop_cnt_r;
  logic                      token_r;
  logic                      push;

  // ----------------------------------------------------------------------
  // calibration check and scoreboard
  // ----------------------------------------------------------------------
  assign sample_ok = io_valid_i & (io_data_i == link_calib_pkg::calib_word[chk_id_r]);

  always_comb begin
    pass_nxt           = pass_r;
    pass_nxt[chk_id_r] = test_ok_r & sample_ok;
  end

  // receive only once this channel has seen the last test
  assign push = io_valid_i & cal_done_r;

  always_ff @(posedge io_master_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chk_en_r      <= 1'b0;
      chk_end_r     <= 1'b0;
      chk_id_r      <= link_calib_pkg::TEST_ONES;
      test_ok_r     <= 1'b1;
      pass_r        <= '0;
      chan_active_r <= 1'b0;
      cal_done_r    <= 1'b0;
      wr_ptr_r      <= '0;
      rd_ptr_r      <= '0;
      pop_cnt_r     <= '0;
      token_r       <= 1'b0;
    end else if (chan_clear_i) begin
      chk_en_r      <= 1'b0;
      chk_end_r     <= 1'b0;
      chk_id_r      <= link_calib_pkg::TEST_ONES;
      test_ok_r     <= 1'b1;
      pass_r        <= '0;
      chan_active_r <= 1'b0;
      cal_done_r    <= 1'b0;
      wr_ptr_r      <= '0;
      rd_ptr_r      <= '0;
      pop_cnt_r     <= '0;
      token_r       <= 1'b0;
    end else begin
      chk_en_r  <= calib_active_i;
      chk_end_r <= test_end_i;
      chk_id_r  <= test_id_i;
      if (chk_en_r) begin
        if (chk_end_r) begin
          // record this test, fresh start for the next one
          pass_r        <= pass_nxt;
          chan_active_r <= &pass_nxt;
          test_ok_r     <= 1'b1;
          if (chk_id_r == last_test)
            cal_done_r <= 1'b1;
        end else begin
          // a mismatch or a missing valid sticks for the rest of the test
          test_ok_r <= test_ok_r & sample_ok;
        end
      end
      // fifo pointers
      if (push)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (core_yumi_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      // one token per completed group of pops
      if (core_yumi_i)
        pop_cnt_r <= pop_cnt_r + 1'b1;
      token_r <= core_yumi_i & (&pop_cnt_r);
    end
  end

  // fifo storage
  always_ff @(posedge io_master_clk_i) begin
    if (push)
      mem[wr_ptr_r[`LG_FIFO_DEPTH-1:0]] <= io_data_i;
  end

  assign core_valid_o  = (wr_ptr_r != rd_ptr_r);
  assign core_data_o   = mem[rd_ptr_r[`LG_FIFO_DEPTH-1:0]];
  assign token_o       = token_r;
  assign chan_active_o = chan_active_r;

endmodule

/* chan_output.sv */
// per-channel output: credit-limited core accept and registered line drive
`timescale 1ns/1ns
`include "link_cfg.svh"

module chan_output (
  input  logic                       io_master_clk_i,
  input  logic                       rst_n_i,
  input  logic                       chan_clear_i,
  input  logic                       calib_active_i,
  input  link_calib_pkg::test_id_e   test_id_i,
  input  logic                       enable_i,
  input  logic                       core_valid_i,
  input  link_chan_pkg::chan_word_t  core_data_i,
  output logic                       core_ready_o,
  input  logic                       token_clk_i,
  output logic                       im_valid_o,
  output link_chan_pkg::chan_word_t  im_data_o
);

  // start credits equal the far fifo depth
  localparam link_chan_pkg::credit_t start_credits = link_chan_pkg::credit_t'(1 << `LG_FIFO_DEPTH);
  // each token refunds one decimation group
  localparam link_chan_pkg::credit_t token_credits = link_chan_pkg::credit_t'(1 << `LG_TOKEN_DECIM);

  link_chan_pkg::credit_t    credit_r;
  link_chan_pkg::credit_t    credit_nxt;
  link_chan_pkg::chan_word_t im_data_r;
  logic                      im_valid_r;
  logic                      token_d_r;
  logic                      clear_d_r;
  logic                      accept;
  logic                      token_edge;

  // ----------------------------------------------------------------------
  // credit accounting
  // ----------------------------------------------------------------------
  assign accept     = core_valid_i & core_ready_o;
  assign token_edge = token_clk_i & ~token_d_r;

  always_comb begin
    credit_nxt = credit_r;
    if (accept)
      credit_nxt = credit_nxt - 1'b1;
    if (token_edge)
      credit_nxt = credit_nxt + token_credits;
  end

  always_ff @(posedge io_master_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_r   <= '0;
      token_d_r  <= 1'b0;
      clear_d_r  <= 1'b0;
      im_valid_r <= 1'b0;
    end else begin
      token_d_r <= token_clk_i;
      clear_d_r <= chan_clear_i;
      // empty while cleared, full fifo depth on the falling edge of clear
      if (chan_clear_i)
        credit_r <= '0;
      else if (clear_d_r)
        credit_r <= start_credits;
      else
        credit_r <= credit_nxt;
      // tests drive the line every cycle
      im_valid_r <= calib_active_i | accept;
    end
  end

  // line data, calibration word during tests, else the accepted word
  always_ff @(posedge io_master_clk_i) begin
    if (calib_active_i)
      im_data_r <= link_calib_pkg::calib_word[test_id_i];
    else if (accept)
      im_data_r <= core_data_i;
  end

  assign core_ready_o = enable_i & (credit_r != '0);
  assign im_valid_o   = im_valid_r;
  assign im_data_o    = im_data_r;

endmodule

/* calib_sequencer.sv */
// calibration control fsm: wait, prepare, run each test, then report done
`timescale 1ns/1ns
`include "link_cfg.svh"

module calib_sequencer (
  input  logic                          io_master_clk_i,
  input  logic                          rst_n_i,
  input  logic [`LINK_CHANNELS-1:0]     chan_active_i,
  output logic                          calib_active_o,
  output link_calib_pkg::test_id_e      test_id_o,
  output logic                          test_end_o,
  output logic                          chan_clear_o,
  output logic                          calib_done_o,
  output logic                          slave_reset_r_o,
  output logic [`LINK_CHANNELS-1:0]     active_channels_o
);

  // one counter serves every phase, sized for the longest one
  localparam int cnt_w = $clog2(`WAIT_CYCLES + `PREPARE_CYCLES + `TEST_CYCLES);
  localparam logic [cnt_w-1:0] wait_last = cnt_w'(`WAIT_CYCLES - 1);
  localparam logic [cnt_w-1:0] prep_last = cnt_w'(`PREPARE_CYCLES - 1);
  localparam logic [cnt_w-1:0] test_last = cnt_w'(`TEST_CYCLES - 1);
  localparam link_calib_pkg::test_id_e last_test =
    link_calib_pkg::test_id_e'(`NUM_TESTS - 1);

  link_calib_pkg::calib_state_e state_r;
  link_calib_pkg::test_id_e     test_id_r;
  logic [cnt_w-1:0]             cnt_r;
  logic                         phase_last;
  logic                         slave_reset_r;
  logic [`LINK_CHANNELS-1:0]    active_channels_r;

  // ----------------------------------------------------------------------
  // phase end decode
  // ----------------------------------------------------------------------
  always_comb begin
    case (state_r)
      link_calib_pkg::ST_WAIT:    phase_last = (cnt_r == wait_last);
      link_calib_pkg::ST_PREPARE: phase_last = (cnt_r == prep_last);
      link_calib_pkg::ST_TEST:    phase_last = (cnt_r == test_last);
      default:                    phase_last = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // state, counter and test index
  // ----------------------------------------------------------------------
  always_ff @(posedge io_master_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r   <= link_calib_pkg::ST_WAIT;
      test_id_r <= link_calib_pkg::TEST_ONES;
      cnt_r     <= '0;
    end else begin
      // counter restarts at each phase boundary, frozen once done
      if (phase_last)
        cnt_r <= '0;
      else if (state_r != link_calib_pkg::ST_DONE)
        cnt_r <= cnt_r + 1'b1;

      if (phase_last) begin
        case (state_r)
          link_calib_pkg::ST_WAIT:    state_r <= link_calib_pkg::ST_PREPARE;
          link_calib_pkg::ST_PREPARE: state_r <= link_calib_pkg::ST_TEST;
          link_calib_pkg::ST_TEST: begin
            // step through the tests, leave after the last one
            if (test_id_r == last_test)
              state_r <= link_calib_pkg::ST_DONE;
            else
              test_id_r <= link_calib_pkg::test_id_e'(test_id_r + 2'd1);
          end
          default: state_r <= state_r;
        endcase
      end
    end
  end

  // slave reset follows prepare with one register of delay,
  // active vector is captured while done
  always_ff @(posedge io_master_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slave_reset_r     <= 1'b0;
      active_channels_r <= '0;
    end else begin
      slave_reset_r <= (state_r == link_calib_pkg::ST_PREPARE);
      if (state_r == link_calib_pkg::ST_DONE)
        active_channels_r <= chan_active_i;
    end
  end

  assign calib_active_o    = (state_r == link_calib_pkg::ST_TEST);
  assign test_id_o         = test_id_r;
  assign test_end_o        = calib_active_o & phase_last;
  // channels stay cleared through wait and prepare
  assign chan_clear_o      = (state_r == link_calib_pkg::ST_WAIT) |
                             (state_r == link_calib_pkg::ST_PREPARE);
  assign calib_done_o      = (state_r == link_calib_pkg::ST_DONE);
  assign slave_reset_r_o   = slave_reset_r;
  assign active_channels_o = active_channels_r;

endmodule

/* link_chan_pkg.sv */
// channel traffic types shared by the output and input channels and the top
`include "link_cfg.svh"

package link_chan_pkg;

  // one word on a link channel
  typedef logic [`CHANNEL_WIDTH-1:0] chan_word_t;

  // credit count, one bit wider than the fifo index
  // so that a full fifo depth of credits fits
  typedef logic [`LG_FIFO_DEPTH:0] credit_t;

endpackage

/* link_calib_pkg.sv */
// calibration types and fixed calibration words, used by the sequencer and channels
`include "link_cfg.svh"

package link_calib_pkg;

  // sequencer phases after reset release
  typedef enum logic [1:0] {
    ST_WAIT    = 2'd0,
    ST_PREPARE = 2'd1,
    ST_TEST    = 2'd2,
    ST_DONE    = 2'd3
  } calib_state_e;

  // calibration tests, run in this order
  typedef enum logic [1:0] {
    TEST_ONES  = 2'd0,
    TEST_ALT_A = 2'd1,
    TEST_ALT_B = 2'd2
  } test_id_e;

  // word sent on every channel during each test, indexed by test_id_e
  // entry 0 all ones, entry 1 8'h55, entry 2 8'haa
  localparam logic [`NUM_TESTS-1:0][`CHANNEL_WIDTH-1:0] calib_word = {
    {(`CHANNEL_WIDTH/2){2'b10}},
    {(`CHANNEL_WIDTH/2){2'b01}},
    {`CHANNEL_WIDTH{1'b1}}
  };

endpackage

/* link_cfg.svh */
// link configuration macros, included by every rtl file and the testbench
`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

// ----------------------------------------------------------------------
// channel geometry
// ----------------------------------------------------------------------
`define LINK_CHANNELS 2
`define CHANNEL_WIDTH 8

// log2 of input fifo slots, also the starting credit count
`define LG_FIFO_DEPTH 3
// log2 of pops per returned token, also credits refunded per token
`define LG_TOKEN_DECIM 1

// ----------------------------------------------------------------------
// calibration timing, in io_master_clk_i cycles
// ----------------------------------------------------------------------
`define WAIT_CYCLES 16
`define PREPARE_CYCLES 32
`define TEST_CYCLES 16
`define NUM_TESTS 3

`endif
